// ==== apb_subsystem.f ====
+incdir+include
logic/apb_subsystem_pkg.sv
logic/apb_if.sv
logic/ahb_apb_bridge.sv
logic/apb_decoder.sv
logic/gpio_regs.sv
logic/timer_unit.sv
logic/irq_ctrl.sv
logic/apb_subsystem.sv
verif/apb_subsystem_tb.sv

// ==== include/apb_subsystem_config.svh ====
// Address map, bus widths and peripheral sizes of the APB subsystem
// Included by the RTL and the testbench wherever a width or map constant is needed
`ifndef APB_SUBSYSTEM_CONFIG_SVH
`define APB_SUBSYSTEM_CONFIG_SVH

// ------------------------------
// Address map
// ------------------------------
`define APB_BASE_ADDR    32'h0080_0000 // Start of peripheral window
`define APB_SLOT_SHIFT   16            // 64 KB per slot
`define APB_NUM_SLOTS    9             // Slots 0..8 as in the full map
`define APB_SLOT_WIDTH   4             // Slot number bits
`define APB_OFFSET_WIDTH 8             // Register offset bits seen by peripherals

// ------------------------------
// Bus and peripheral widths
// ------------------------------
`define APB_DATA_WIDTH   32
`define GPIO_WIDTH       16
`define TIMER_WIDTH      16

// Interrupt sources
`define NUM_EXT_IRQS     5             // DMA, MAC0..MAC3
`define NUM_IRQ_SRC      7             // GPIO, timer, then the external ones

`endif

// ==== logic/ahb_apb_bridge.sv ====
// AHB-lite slave front end, each word transfer becomes one APB setup and access
// Data phase is always two cycles, hready low in setup and high in access
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_config.svh"

module ahb_apb_bridge import apb_subsystem_pkg::*; (
  input  wire logic                       i_hclk,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_hsel,
  input  wire logic [31:0]                i_haddr,
  input  wire logic [1:0]                 i_htrans,
  input  wire logic                       i_hwrite,
  input  wire logic [`APB_DATA_WIDTH-1:0] i_hwdata,
  input  wire logic                       i_hready_in,
  output logic      [`APB_DATA_WIDTH-1:0] o_hrdata,
  output logic                            o_hready,
  apb_if.master                           bus_m
);

  bridge_state_e              state_q;
  bridge_state_e              state_d;
  logic [31:0]                addr_q;  // Address phase capture
  logic                       write_q;
  logic [`APB_DATA_WIDTH-1:0] wdata_q; // hwdata held for access phase
  logic                       accept;

  // NONSEQ and SEQ both have htrans[1] set, IDLE and BUSY are dropped
  assign accept = i_hsel & i_hready_in & o_hready & i_htrans[1];

  // ------------------------------
  // Phase sequencing
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = SETUP;
        end
      end
      SETUP:   state_d = ACCESS;
      ACCESS:  state_d = accept ? SETUP : IDLE; // Back to back transfers
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_hclk) begin
    if (!i_rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address, direction and write data capture
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      addr_q  <= i_haddr;
      write_q <= i_hwrite;
    end
    if (state_q == SETUP) begin
      wdata_q <= i_hwdata; // Sampled in setup
    end
  end

  // ------------------------------
  // APB side
  // ------------------------------
  assign bus_m.psel    = (state_q != IDLE);
  assign bus_m.penable = (state_q == ACCESS);
  assign bus_m.pwrite  = write_q;
  assign bus_m.paddr   = addr_q;
  assign bus_m.pwdata  = (state_q == SETUP) ? i_hwdata : wdata_q;

  // AHB response
  assign o_hready = (state_q != SETUP); // Only back-pressure
  assign o_hrdata = (state_q == ACCESS && !write_q) ? bus_m.prdata : '0;

endmodule

`default_nettype wire

// ==== logic/apb_decoder.sv ====
// Slot decoder for the peripheral window
// Raises one psel, fans out the shared APB signals and muxes read data back
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_config.svh"

module apb_decoder import apb_subsystem_pkg::*; (
  apb_if.slave  bus_m,  // From bridge, full address
  apb_if.master gpio_s, // Slot 2
  apb_if.master tmr_s,  // Slot 3
  apb_if.master irq_s   // Slot 6
);

  localparam logic [31:0] BASE = `APB_BASE_ADDR;
  localparam int          HI_W = 32 - `APB_SLOT_SHIFT; // Slot field and above

  logic [HI_W-1:0] slot_idx;  // Slot count from the base
  logic            in_window;
  apb_slot_e       slot;

  // Below the base wraps to a large value and falls outside
  assign slot_idx  = bus_m.paddr[31:`APB_SLOT_SHIFT] - BASE[31:`APB_SLOT_SHIFT];
  assign in_window = (slot_idx < `APB_NUM_SLOTS);
  assign slot      = apb_slot_e'(slot_idx[`APB_SLOT_WIDTH-1:0]);

  // One-hot select, unused slots get nothing
  assign gpio_s.psel = bus_m.psel & in_window & (slot == SLOT_GPIO);
  assign tmr_s.psel  = bus_m.psel & in_window & (slot == SLOT_TIMER);
  assign irq_s.psel  = bus_m.psel & in_window & (slot == SLOT_IRQ);

  // Shared controls and low offset bits
  assign gpio_s.penable = bus_m.penable;
  assign tmr_s.penable  = bus_m.penable;
  assign irq_s.penable  = bus_m.penable;
  assign gpio_s.pwrite  = bus_m.pwrite;
  assign tmr_s.pwrite   = bus_m.pwrite;
  assign irq_s.pwrite   = bus_m.pwrite;
  assign gpio_s.paddr   = bus_m.paddr[`APB_OFFSET_WIDTH-1:0];
  assign tmr_s.paddr    = bus_m.paddr[`APB_OFFSET_WIDTH-1:0];
  assign irq_s.paddr    = bus_m.paddr[`APB_OFFSET_WIDTH-1:0];
  assign gpio_s.pwdata  = bus_m.pwdata;
  assign tmr_s.pwdata   = bus_m.pwdata;
  assign irq_s.pwdata   = bus_m.pwdata;

  // Read data return, unmatched slots read zero
  always_comb begin
    bus_m.prdata = '0;
    if (in_window) begin
      case (slot)
        SLOT_GPIO:  bus_m.prdata = gpio_s.prdata;
        SLOT_TIMER: bus_m.prdata = tmr_s.prdata;
        SLOT_IRQ:   bus_m.prdata = irq_s.prdata;
        default:    bus_m.prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/apb_if.sv ====
// APB bus segment without pready, one instance per segment
// Master modport sits on the requesting side, slave modport returns read data
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_config.svh"

interface apb_if #(
  parameter int ADDR_WIDTH = `APB_OFFSET_WIDTH // Full 32 bits on the bridge segment
);

  logic                       psel;    // Slot select
  logic                       penable; // High in access phase
  logic                       pwrite;  // 1 = write
  logic [ADDR_WIDTH-1:0]      paddr;
  logic [`APB_DATA_WIDTH-1:0] pwdata;
  logic [`APB_DATA_WIDTH-1:0] prdata;  // Combinational from the slave

  modport master (output psel, penable, pwrite, paddr, pwdata, input prdata);
  modport slave  (input psel, penable, pwrite, paddr, pwdata, output prdata);

endinterface

`default_nettype wire

// ==== logic/apb_subsystem.sv ====
// Top level of the APB peripheral subsystem behind an AHB-lite slave port
// Bridge, slot decoder, GPIO, interval timer and interrupt collector
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_config.svh"

module apb_subsystem (
  input  wire logic                       i_hclk,
  input  wire logic                       i_rst_n,
  // AHB-lite slave
  input  wire logic                       i_hsel,
  input  wire logic [31:0]                i_haddr,
  input  wire logic [1:0]                 i_htrans,
  input  wire logic                       i_hwrite,
  input  wire logic [`APB_DATA_WIDTH-1:0] i_hwdata,
  input  wire logic                       i_hready_in,
  output logic      [`APB_DATA_WIDTH-1:0] o_hrdata,
  output logic                            o_hready,
  // GPIO pins
  input  wire logic [`GPIO_WIDTH-1:0]     i_gpio_pin,
  output logic      [`GPIO_WIDTH-1:0]     o_gpio_pin,
  output logic      [`GPIO_WIDTH-1:0]     o_gpio_n_oe,
  // Interrupts and wake-up
  output logic                            o_gpio_irq,
  output logic                            o_timer_irq,
  input  wire logic [`NUM_EXT_IRQS-1:0]   i_ext_irq,
  output logic                            o_irq,
  output logic                            o_wake
);

  // ------------------------------
  // Bus segments
  // ------------------------------
  apb_if #(.ADDR_WIDTH(32)) bus_m ();  // Bridge to decoder, full address
  apb_if                    gpio_s (); // Offset only on peripheral side
  apb_if                    tmr_s ();
  apb_if                    irq_s ();

  ahb_apb_bridge i_ahb_apb_bridge (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hwdata    (i_hwdata),
    .i_hready_in (i_hready_in),
    .o_hrdata    (o_hrdata),
    .o_hready    (o_hready),
    .bus_m       (bus_m)
  );

  apb_decoder i_apb_decoder (
    .bus_m  (bus_m),
    .gpio_s (gpio_s),
    .tmr_s  (tmr_s),
    .irq_s  (irq_s)
  );

  // ------------------------------
  // Peripherals
  // ------------------------------
  gpio_regs i_gpio_regs (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .gpio_s      (gpio_s),
    .i_gpio_pin  (i_gpio_pin),
    .o_gpio_pin  (o_gpio_pin),
    .o_gpio_n_oe (o_gpio_n_oe),
    .o_gpio_irq  (o_gpio_irq)  // Also feeds the collector
  );

  timer_unit i_timer_unit (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .tmr_s       (tmr_s),
    .o_timer_irq (o_timer_irq)
  );

  irq_ctrl i_irq_ctrl (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .irq_s       (irq_s),
    .i_gpio_irq  (o_gpio_irq),
    .i_timer_irq (o_timer_irq),
    .i_ext_irq   (i_ext_irq),
    .o_irq       (o_irq),
    .o_wake      (o_wake)
  );

endmodule

`default_nettype wire

// ==== logic/apb_subsystem_pkg.sv ====
// Shared types of the APB subsystem
// Bridge FSM states, slot numbers and register offsets of each peripheral
`default_nettype none

`include "apb_subsystem_config.svh"

package apb_subsystem_pkg;

  // AHB to APB bridge phases
  typedef enum logic [1:0] {
    IDLE,   // No transfer in flight
    SETUP,  // APB setup phase, hready low
    ACCESS  // APB access phase, hready high
  } bridge_state_e;

  // Peripheral slots in the window
  typedef enum logic [`APB_SLOT_WIDTH-1:0] {
    SLOT_GPIO  = 4'd2,
    SLOT_TIMER = 4'd3,
    SLOT_IRQ   = 4'd6
  } apb_slot_e;

  // GPIO register offsets
  typedef enum logic [`APB_OFFSET_WIDTH-1:0] {
    GPIO_OUT  = 8'h00,
    GPIO_OE   = 8'h04,
    GPIO_IN   = 8'h08,
    GPIO_MASK = 8'h0C,
    GPIO_STAT = 8'h10
  } gpio_reg_e;

  // Timer register offsets
  typedef enum logic [`APB_OFFSET_WIDTH-1:0] {
    TMR_CTRL  = 8'h00, // Bit0 enable, bit1 interrupt enable
    TMR_LOAD  = 8'h04,
    TMR_COUNT = 8'h08,
    TMR_STAT  = 8'h0C
  } timer_reg_e;

  // Interrupt collector register offsets
  typedef enum logic [`APB_OFFSET_WIDTH-1:0] {
    IRQ_RAW       = 8'h00,
    IRQ_MASK      = 8'h04,
    IRQ_PEND      = 8'h08,
    IRQ_HIBERNATE = 8'h0C // Bit0 only
  } irq_reg_e;

endpackage

`default_nettype wire

// ==== logic/gpio_regs.sv ====
// GPIO block with output, output enable, synchronized inputs and change interrupt
// Status bits are sticky and cleared by writing 1
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_config.svh"

module gpio_regs import apb_subsystem_pkg::*; (
  input  wire logic                  i_hclk,
  input  wire logic                  i_rst_n,
  apb_if.slave                       gpio_s,
  input  wire logic [`GPIO_WIDTH-1:0] i_gpio_pin,
  output logic      [`GPIO_WIDTH-1:0] o_gpio_pin,
  output logic      [`GPIO_WIDTH-1:0] o_gpio_n_oe, // Active low enable
  output logic                        o_gpio_irq
);

  localparam int PAD = `APB_DATA_WIDTH - `GPIO_WIDTH;

  logic [`GPIO_WIDTH-1:0] out_q;
  logic [`GPIO_WIDTH-1:0] oe_q;    // 1 = pin driven
  logic [`GPIO_WIDTH-1:0] mask_q;
  logic [`GPIO_WIDTH-1:0] stat_q;
  logic [`GPIO_WIDTH-1:0] sync1_q; // First sync stage
  logic [`GPIO_WIDTH-1:0] sync2_q; // GPIO_IN value
  logic [`GPIO_WIDTH-1:0] prev_q;  // Last GPIO_IN for edge detect
  logic [`GPIO_WIDTH-1:0] change;
  logic [`GPIO_WIDTH-1:0] stat_clr;
  logic [`GPIO_WIDTH-1:0] wdata;
  logic                   wr_en;
  gpio_reg_e              reg_sel;

  assign wr_en    = gpio_s.psel & gpio_s.penable & gpio_s.pwrite; // End of access
  assign reg_sel  = gpio_reg_e'(gpio_s.paddr);
  assign wdata    = gpio_s.pwdata[`GPIO_WIDTH-1:0];
  assign change   = sync2_q ^ prev_q;
  assign stat_clr = (wr_en && reg_sel == GPIO_STAT) ? wdata : '0;

  always_ff @(posedge i_hclk) begin
    if (!i_rst_n) begin
      out_q   <= '0;
      oe_q    <= '0;
      mask_q  <= '0;
      stat_q  <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= i_gpio_pin;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      stat_q  <= (stat_q & ~stat_clr) | change; // New change wins over clear
      if (wr_en && reg_sel == GPIO_OUT) begin
        out_q <= wdata;
      end
      if (wr_en && reg_sel == GPIO_OE) begin
        oe_q <= wdata;
      end
      if (wr_en && reg_sel == GPIO_MASK) begin
        mask_q <= wdata;
      end
    end
  end

  // Register read mux
  always_comb begin
    case (reg_sel)
      GPIO_OUT:  gpio_s.prdata = {{PAD{1'b0}}, out_q};
      GPIO_OE:   gpio_s.prdata = {{PAD{1'b0}}, oe_q};
      GPIO_IN:   gpio_s.prdata = {{PAD{1'b0}}, sync2_q};
      GPIO_MASK: gpio_s.prdata = {{PAD{1'b0}}, mask_q};
      GPIO_STAT: gpio_s.prdata = {{PAD{1'b0}}, stat_q};
      default:   gpio_s.prdata = '0;
    endcase
  end

  assign o_gpio_pin  = out_q;
  assign o_gpio_n_oe = ~oe_q;              // All 1s out of reset
  assign o_gpio_irq  = |(stat_q & mask_q);

endmodule

`default_nettype wire

// ==== logic/irq_ctrl.sv ====
// Interrupt collector, masks the seven sources into one combined interrupt
// Also raises the wake-up request, GPIO only while the hibernate flag is set
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_config.svh"

module irq_ctrl import apb_subsystem_pkg::*; (
  input  wire logic                     i_hclk,
  input  wire logic                     i_rst_n,
  apb_if.slave                          irq_s,
  input  wire logic                     i_gpio_irq,
  input  wire logic                     i_timer_irq,
  input  wire logic [`NUM_EXT_IRQS-1:0] i_ext_irq, // DMA, MAC0..MAC3
  output logic                          o_irq,
  output logic                          o_wake
);

  localparam int PAD = `APB_DATA_WIDTH - `NUM_IRQ_SRC;

  logic [`NUM_IRQ_SRC-1:0] raw_src; // Bit0 GPIO, bit1 timer, then external
  logic [`NUM_IRQ_SRC-1:0] mask_q;
  logic [`NUM_IRQ_SRC-1:0] pend;
  logic                    hib_q;   // Hibernate flag
  logic                    wr_en;
  irq_reg_e                reg_sel;

  assign raw_src = {i_ext_irq, i_timer_irq, i_gpio_irq};
  assign pend    = raw_src & mask_q;
  assign wr_en   = irq_s.psel & irq_s.penable & irq_s.pwrite;
  assign reg_sel = irq_reg_e'(irq_s.paddr);

  always_ff @(posedge i_hclk) begin
    if (!i_rst_n) begin
      mask_q <= '0;
      hib_q  <= 1'b0;
      o_wake <= 1'b0;
    end else begin
      if (wr_en && reg_sel == IRQ_MASK) begin
        mask_q <= irq_s.pwdata[`NUM_IRQ_SRC-1:0];
      end
      if (wr_en && reg_sel == IRQ_HIBERNATE) begin
        hib_q <= irq_s.pwdata[0];
      end
      // Hibernation only wakes on GPIO, sleep wakes on any raw source
      o_wake <= hib_q ? i_gpio_irq : |raw_src;
    end
  end

  always_comb begin
    case (reg_sel)
      IRQ_RAW:       irq_s.prdata = {{PAD{1'b0}}, raw_src};
      IRQ_MASK:      irq_s.prdata = {{PAD{1'b0}}, mask_q};
      IRQ_PEND:      irq_s.prdata = {{PAD{1'b0}}, pend};
      IRQ_HIBERNATE: irq_s.prdata = {{(`APB_DATA_WIDTH-1){1'b0}}, hib_q};
      default:       irq_s.prdata = '0;
    endcase
  end

  assign o_irq = |pend; // Unmasked sources only

endmodule

`default_nettype wire

// ==== logic/timer_unit.sv ====
// Interval timer, one down counter that reloads from LOAD on reaching zero
// Each reload sets a sticky status bit, cleared by writing 1
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_config.svh"

module timer_unit import apb_subsystem_pkg::*; (
  input  wire logic i_hclk,
  input  wire logic i_rst_n,
  apb_if.slave      tmr_s,
  output logic      o_timer_irq
);

  localparam int PAD = `APB_DATA_WIDTH - `TIMER_WIDTH;

  logic [1:0]              ctrl_q;  // Bit1 irq enable, bit0 count enable
  logic [`TIMER_WIDTH-1:0] load_q;
  logic [`TIMER_WIDTH-1:0] count_q;
  logic                    stat_q;
  logic                    wr_en;
  logic                    load_wr;
  logic                    tick;    // Period end
  logic                    stat_clr;
  timer_reg_e              reg_sel;

  assign wr_en    = tmr_s.psel & tmr_s.penable & tmr_s.pwrite;
  assign reg_sel  = timer_reg_e'(tmr_s.paddr);
  assign load_wr  = wr_en && reg_sel == TMR_LOAD;
  assign stat_clr = wr_en && reg_sel == TMR_STAT && tmr_s.pwdata[0];
  assign tick     = ctrl_q[0] && count_q == '0 && !load_wr; // Every LOAD+1 cycles

  always_ff @(posedge i_hclk) begin
    if (!i_rst_n) begin
      ctrl_q  <= '0;
      load_q  <= '0;
      count_q <= '0;
      stat_q  <= 1'b0;
    end else begin
      if (wr_en && reg_sel == TMR_CTRL) begin
        ctrl_q <= tmr_s.pwdata[1:0];
      end
      // New LOAD restarts the count so COUNT stays within LOAD
      if (load_wr) begin
        load_q  <= tmr_s.pwdata[`TIMER_WIDTH-1:0];
        count_q <= tmr_s.pwdata[`TIMER_WIDTH-1:0];
      end else if (ctrl_q[0]) begin
        count_q <= (count_q == '0) ? load_q : count_q - 1'b1;
      end
      stat_q <= (stat_q & ~stat_clr) | tick;
    end
  end

  always_comb begin
    case (reg_sel)
      TMR_CTRL:  tmr_s.prdata = {{(`APB_DATA_WIDTH-2){1'b0}}, ctrl_q};
      TMR_LOAD:  tmr_s.prdata = {{PAD{1'b0}}, load_q};
      TMR_COUNT: tmr_s.prdata = {{PAD{1'b0}}, count_q};
      TMR_STAT:  tmr_s.prdata = {{(`APB_DATA_WIDTH-1){1'b0}}, stat_q};
      default:   tmr_s.prdata = '0;
    endcase
  end

  assign o_timer_irq = stat_q & ctrl_q[1];

endmodule

`default_nettype wire

// ==== verif/apb_subsystem_tb.sv ====
// Testbench for the APB subsystem driving AHB-lite transfers into every kept peripheral
// Immediate assertions check registers, pins, interrupts and the wake-up request
`timescale 1ns/10ps
`default_nettype none

`include "apb_subsystem_config.svh"

module apb_subsystem_tb import apb_subsystem_pkg::*; ();

  localparam int         TIMEOUT       = 40;    // Cycle or read limit of each wait loop
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  logic                       hclk;
  logic                       rst_n;
  logic                       hsel;
  logic [31:0]                haddr;
  logic [1:0]                 htrans;
  logic                       hwrite;
  logic [`APB_DATA_WIDTH-1:0] hwdata;
  logic                       hready_in;
  logic [`APB_DATA_WIDTH-1:0] hrdata;
  logic                       hready;
  logic [`GPIO_WIDTH-1:0]     gpio_pin_in;
  logic [`GPIO_WIDTH-1:0]     gpio_pin_out;
  logic [`GPIO_WIDTH-1:0]     gpio_n_oe;
  logic                       gpio_irq;
  logic                       timer_irq;
  logic [`NUM_EXT_IRQS-1:0]   ext_irq;
  logic                       irq;
  logic                       wake;
  int                         checks;
  int                         errors;
  int                         timeouts;

  apb_subsystem i_apb_subsystem (
    .i_hclk (hclk), .i_rst_n (rst_n), .i_hsel (hsel), .i_haddr (haddr),
    .i_htrans (htrans), .i_hwrite (hwrite), .i_hwdata (hwdata),
    .i_hready_in (hready_in), .o_hrdata (hrdata), .o_hready (hready),
    .i_gpio_pin (gpio_pin_in), .o_gpio_pin (gpio_pin_out), .o_gpio_n_oe (gpio_n_oe),
    .o_gpio_irq (gpio_irq), .o_timer_irq (timer_irq), .i_ext_irq (ext_irq),
    .o_irq (irq), .o_wake (wake)
  );

  initial begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk; // 10 ns period
  end

  // ------------------------------
  // Bus helpers
  // ------------------------------
  function automatic logic [31:0] reg_addr(input logic [3:0] slot, input logic [7:0] off);
    logic [31:0] slot_w;
    slot_w = slot; // Zero extend before the shift
    return `APB_BASE_ADDR + (slot_w << `APB_SLOT_SHIFT) + off;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // One AHB transfer as address phase then SETUP and ACCESS
  task automatic transfer(input logic write, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int low_cycles;
    @(negedge hclk);
    hsel   = 1'b1;
    haddr  = addr;
    htrans = HTRANS_NONSEQ;
    hwrite = write;
    @(negedge hclk);
    hsel   = 1'b0;          // Nothing new while the data phase runs
    htrans = HTRANS_IDLE;
    hwdata = wdata;
    low_cycles = 0;
    while (!hready && low_cycles < TIMEOUT) begin
      low_cycles++;
      @(negedge hclk);
    end
    if (!hready) begin
      timeouts++;
      $display("Timeout: o_hready stayed low after a transfer to 0x%08h", addr);
    end
    check_eq("o_hready low cycles", low_cycles, 1);
    rdata = hrdata;          // Valid in ACCESS
  endtask

  task automatic write_reg(input logic [3:0] slot, input logic [7:0] off, input logic [31:0] data);
    logic [31:0] unused;
    transfer(1'b1, reg_addr(slot, off), data, unused);
  endtask

  task automatic read_reg(input logic [3:0] slot, input logic [7:0] off, output logic [31:0] data);
    transfer(1'b0, reg_addr(slot, off), '0, data);
  endtask

  task automatic expect_reg(input string name, input logic [3:0] slot, input logic [7:0] off,
                            input logic [31:0] exp);
    logic [31:0] rd;
    read_reg(slot, off, rd);
    check_eq(name, rd, exp);
  endtask

  // Reads until the masked value matches
  task automatic poll_reg(input string name, input logic [3:0] slot, input logic [7:0] off,
                          input logic [31:0] mask, input logic [31:0] exp);
    logic [31:0] rd;
    int          n;
    n = 0;
    read_reg(slot, off, rd);
    while ((rd & mask) !== exp && n < TIMEOUT) begin
      read_reg(slot, off, rd);
      n++;
    end
    if ((rd & mask) !== exp) begin
      timeouts++;
      $display("Timeout: %s never reached the expected value", name);
    end
  endtask

  task automatic wait_wake(input logic level);
    int n;
    n = 0;
    while (wake !== level && n < TIMEOUT) begin
      @(negedge hclk);
      n++;
    end
    if (wake !== level) begin
      timeouts++;
      $display("Timeout: o_wake did not go to %0d", level);
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    int                     seed_dummy;
    int                     b;
    int                     c;
    logic [31:0]            rd;
    logic [31:0]            mask_v;
    logic [31:0]            exp_v;
    logic [31:0]            load_v;
    logic [`GPIO_WIDTH-1:0] out_v;
    logic [`GPIO_WIDTH-1:0] oe_v;
    logic [`GPIO_WIDTH-1:0] n_oe_v;
    logic [`GPIO_WIDTH-1:0] pin_v;
    seed_dummy = $urandom(32'h10ef);
    checks = 0;
    errors = 0;
    timeouts = 0;
    rst_n = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hwdata = '0;
    hready_in = 1'b1; // No other slave on the bus
    gpio_pin_in = '0;
    ext_irq = '0;
    repeat (5) @(posedge hclk);
    @(negedge hclk);
    rst_n = 1'b1;

    // Reset values
    check_eq("o_hready", hready, 1'b1);
    check_eq("o_gpio_n_oe", gpio_n_oe, 16'hffff);
    check_eq("o_gpio_pin", gpio_pin_out, 0);
    check_eq("o_gpio_irq", gpio_irq, 0);
    check_eq("o_timer_irq", timer_irq, 0);
    check_eq("o_irq", irq, 0);
    check_eq("o_wake", wake, 0);
    expect_reg("GPIO_OUT", SLOT_GPIO, GPIO_OUT, 0);
    expect_reg("GPIO_OE", SLOT_GPIO, GPIO_OE, 0);
    expect_reg("GPIO_IN", SLOT_GPIO, GPIO_IN, 0);
    expect_reg("GPIO_MASK", SLOT_GPIO, GPIO_MASK, 0);
    expect_reg("GPIO_STAT", SLOT_GPIO, GPIO_STAT, 0);
    expect_reg("TMR_CTRL", SLOT_TIMER, TMR_CTRL, 0);
    expect_reg("TMR_LOAD", SLOT_TIMER, TMR_LOAD, 0);
    expect_reg("TMR_COUNT", SLOT_TIMER, TMR_COUNT, 0);
    expect_reg("TMR_STAT", SLOT_TIMER, TMR_STAT, 0);
    expect_reg("IRQ_RAW", SLOT_IRQ, IRQ_RAW, 0);
    expect_reg("IRQ_MASK", SLOT_IRQ, IRQ_MASK, 0);
    expect_reg("IRQ_PEND", SLOT_IRQ, IRQ_PEND, 0);
    expect_reg("IRQ_HIBERNATE", SLOT_IRQ, IRQ_HIBERNATE, 0);
    write_reg(4'd4, 8'h00, $urandom); // Unused slot ignores writes
    expect_reg("slot 4 read", 4'd4, 8'h00, 0);

    // GPIO outputs and synchronized input
    out_v = $urandom;
    oe_v  = $urandom;
    n_oe_v = ~oe_v;
    write_reg(SLOT_GPIO, GPIO_OUT, out_v);
    expect_reg("GPIO_OUT", SLOT_GPIO, GPIO_OUT, out_v);
    check_eq("o_gpio_pin", gpio_pin_out, out_v);
    write_reg(SLOT_GPIO, GPIO_OE, oe_v);
    expect_reg("GPIO_OE", SLOT_GPIO, GPIO_OE, oe_v);
    check_eq("o_gpio_n_oe", gpio_n_oe, n_oe_v);
    pin_v = $urandom;
    @(negedge hclk);
    gpio_pin_in = pin_v;
    poll_reg("GPIO_IN", SLOT_GPIO, GPIO_IN, 32'hffff, pin_v);
    expect_reg("GPIO_IN", SLOT_GPIO, GPIO_IN, pin_v);

    // Change interrupt with bit b masked in and bit c masked out
    b = $urandom % `GPIO_WIDTH;
    c = (b + 1 + $urandom % (`GPIO_WIDTH - 1)) % `GPIO_WIDTH;
    write_reg(SLOT_GPIO, GPIO_STAT, 32'hffff);
    expect_reg("GPIO_STAT", SLOT_GPIO, GPIO_STAT, 0);
    write_reg(SLOT_GPIO, GPIO_MASK, 32'd1 << b);
    @(negedge hclk);
    gpio_pin_in = gpio_pin_in ^ (16'd1 << c);
    poll_reg("GPIO_STAT", SLOT_GPIO, GPIO_STAT, 32'd1 << c, 32'd1 << c);
    check_eq("o_gpio_irq", gpio_irq, 0); // Bit c is masked out
    @(negedge hclk);
    gpio_pin_in = gpio_pin_in ^ (16'd1 << b);
    poll_reg("GPIO_STAT", SLOT_GPIO, GPIO_STAT, 32'd1 << b, 32'd1 << b);
    check_eq("o_gpio_irq", gpio_irq, 1);
    wait_wake(1'b1); // GPIO alone wakes while awake
    write_reg(SLOT_GPIO, GPIO_STAT, (32'd1 << b) | (32'd1 << c));
    expect_reg("GPIO_STAT", SLOT_GPIO, GPIO_STAT, 0);
    check_eq("o_gpio_irq", gpio_irq, 0);

    // Timer with a short period
    load_v = 2 + $urandom % 6;
    write_reg(SLOT_TIMER, TMR_LOAD, load_v);
    write_reg(SLOT_TIMER, TMR_CTRL, 32'h3);
    c = 0;
    while (!timer_irq && c < TIMEOUT) begin
      read_reg(SLOT_TIMER, TMR_COUNT, rd);
      checks++;
      assert (rd <= load_v) else begin
        errors++;
        $display("CHECK FAILED TMR_COUNT: got 0x%08h, above LOAD 0x%08h", rd, load_v);
      end
      c++;
    end
    if (!timer_irq) begin
      timeouts++;
      $display("Timeout: o_timer_irq never rose");
    end
    wait_wake(1'b1); // Timer alone wakes while awake
    write_reg(SLOT_TIMER, TMR_CTRL, 32'h2); // Stop counting but keep irq enable
    expect_reg("TMR_STAT", SLOT_TIMER, TMR_STAT, 1);
    write_reg(SLOT_TIMER, TMR_STAT, 32'h1);
    expect_reg("TMR_STAT", SLOT_TIMER, TMR_STAT, 0);
    check_eq("o_timer_irq", timer_irq, 0);
    write_reg(SLOT_TIMER, TMR_CTRL, 32'h0);

    // Interrupt collector raw vector then masking
    for (int i = 0; i < `NUM_EXT_IRQS; i++) begin
      @(negedge hclk);
      ext_irq = 5'd1 << i;
      expect_reg("IRQ_RAW", SLOT_IRQ, IRQ_RAW, 32'd1 << (i + 2)); // Above GPIO and timer
      check_eq("o_irq", irq, 0);
    end
    for (int i = 0; i < 4; i++) begin
      mask_v = $urandom & 32'h7f;
      write_reg(SLOT_IRQ, IRQ_MASK, mask_v);
      expect_reg("IRQ_MASK", SLOT_IRQ, IRQ_MASK, mask_v);
      @(negedge hclk);
      ext_irq = $urandom;
      exp_v = {ext_irq, 2'b00} & mask_v;
      expect_reg("IRQ_PEND", SLOT_IRQ, IRQ_PEND, exp_v);
      check_eq("o_irq", irq, |exp_v);
    end
    @(negedge hclk);
    ext_irq = '0;

    // Wake-up on any source while awake and on GPIO only in hibernation
    wait_wake(1'b0);
    for (int i = 0; i < `NUM_EXT_IRQS; i++) begin
      ext_irq = 5'd1 << i;
      wait_wake(1'b1);
      ext_irq = '0;
      wait_wake(1'b0);
    end
    write_reg(SLOT_IRQ, IRQ_HIBERNATE, 32'h1);
    expect_reg("IRQ_HIBERNATE", SLOT_IRQ, IRQ_HIBERNATE, 1);
    ext_irq = '1;
    for (int i = 0; i < 5; i++) begin
      @(negedge hclk);
      check_eq("o_wake", wake, 0);
    end
    ext_irq = '0;
    gpio_pin_in = gpio_pin_in ^ (16'd1 << b); // Masked GPIO bit
    wait_wake(1'b1);
    check_eq("o_gpio_irq", gpio_irq, 1);
    write_reg(SLOT_GPIO, GPIO_STAT, 32'd1 << b);
    wait_wake(1'b0);
    write_reg(SLOT_IRQ, IRQ_HIBERNATE, 32'h0);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
